/* board_defs.svh */
/*
 * board register block constants
 *   address block number and channel count
 *   firmware version and git describe fields
 *   watchdog counter resolution, reset period and phase thresholds
 */
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// --------------------
// address space
`define ADDR_MAIN           4'd0        // board space block, reg address [15:12]
`define NUM_CHAN            4           // number of channel register files

// --------------------
// firmware identity
`define FW_VERSION          32'd9
`define GIT_SHA             28'h3a7c91e // abbreviated commit hash
`define GIT_DIRTY           1'b0        // uncommitted changes in the build tree
`define GIT_COMMITS         2           // commits since the release tag
`define GIT_FW_VERSION      32'd8       // version of the last release tag

// --------------------
// watchdog
`define WDOG_FRAC_BITS      8           // counter bits below period resolution
`define WDOG_PERIOD_RESET   16'h1680    // about 30 ms at 49.152 MHz
`define WDOG_TH1            16'h2580    // upper edge of phase one, 50 ms
`define WDOG_TH2            16'h4B00    // 100 ms
`define WDOG_TH3            16'h7080    // 150 ms
`define WDOG_TH4            16'h9600    // 200 ms, above this is phase five

`endif

/* board_pkg.sv */
/*
 * shared types of the board register block
 *   register offset and watchdog phase enums
 *   host write bus and channel config structs
 */
package board_pkg;

    // offsets within a block, reg address [3:0]
    typedef enum logic [3:0] {
        REG_STATUS   = 4'd0,    // reboot request bits [21:20]
        REG_PHYCTRL  = 4'd1,    // phy request bitstream
        REG_PHYDATA  = 4'd2,    // phy register transfer data
        REG_TIMEOUT  = 4'd3,    // watchdog period and led select
        REG_FVERSION = 4'd4,
        REG_GIT_DESC = 4'd5
    } reg_off_e;

    // channel blocks reuse the low offset codes
    localparam reg_off_e REG_DAC_SET   = REG_STATUS;
    localparam reg_off_e REG_CHAN_CTRL = REG_PHYCTRL;

    // watchdog period classes, shown on the status led
    typedef enum logic [2:0] {
        WDOG_DISABLE = 3'd0,    // period 0, no counting
        PHASE_ONE    = 3'd1,
        PHASE_TWO    = 3'd2,
        PHASE_THREE  = 3'd3,
        PHASE_FOUR   = 3'd4,
        PHASE_FIVE   = 3'd5
    } wdog_phase_e;

    typedef struct packed {
        logic [3:0]  off;       // register offset in the selected block
        logic [31:0] data;
    } bus_wr_t;

    typedef struct packed {
        logic [15:0] dac_setpoint;
        logic        enable;
        logic [2:0]  mode;
    } chan_cfg_t;

endpackage

/* board_regs.sv */
/*
 * general board register file
 *   phy control and data readback
 *   watchdog period and led select, reboot request
 *   firmware version and git describe word
 */
`timescale 1ns/1ns
`include "board_defs.svh"

module board_regs (
    input  logic                   sysclk,
    input  logic                   rst,
    input  board_pkg::bus_wr_t     wr_bus,
    input  logic                   board_wen,
    input  logic [3:0]             read_off,
    input  board_pkg::wdog_phase_e wdog_phase,      // shown in REG_TIMEOUT [18:16]
    output logic [31:0]            board_rdata,
    output logic                   reboot,          // fpga reboot request
    output logic [15:0]            wdog_period,     // upper counter bits compare value
    output logic                   wdog_period_led  // 1 -> led shows the period phase
);
    import board_pkg::*;

    logic [15:0] phy_ctrl;  // phy request bitstream, processed elsewhere
    logic [15:0] phy_data;  // phy register transfer data
    wire  [31:0] git_desc;

    // --------------------
    // git describe word
    assign git_desc[31:4] = `GIT_SHA;
    assign git_desc[3]    = `GIT_DIRTY;

    generate
        if (`GIT_COMMITS == 0) begin : g_at_tag
            assign git_desc[2] = 1'b0;
        end else begin : g_past_tag
            assign git_desc[2] = 1'b1;      // commits on top of the tag
        end

        // low bits relate FW_VERSION to the tagged version
        if (`FW_VERSION == `GIT_FW_VERSION) begin : g_release
            assign git_desc[1:0] = 2'd0;    // release or post release update
        end else if (`FW_VERSION == `GIT_FW_VERSION + 1) begin : g_preview
            assign git_desc[1:0] = 2'd1;    // preview of the next release
        end else if (`FW_VERSION > `GIT_FW_VERSION + 1) begin : g_ahead
            assign git_desc[1:0] = 2'd2;    // version gap, unexpected
        end else begin : g_behind
            assign git_desc[1:0] = 2'd3;    // older than the tag, unexpected
        end
    endgenerate

    // --------------------
    // register writes
    always_ff @(posedge sysclk) begin
        if (rst) begin
            reboot          <= 1'b0;
            phy_ctrl        <= 16'd0;
            phy_data        <= 16'd0;
            wdog_period     <= `WDOG_PERIOD_RESET;
            wdog_period_led <= 1'b0;
        end else if (board_wen) begin
            case (wr_bus.off)
                REG_STATUS:  reboot <= wr_bus.data[21] ? wr_bus.data[20] : 1'b0;  // [21] arms
                REG_PHYCTRL: phy_ctrl <= wr_bus.data[15:0];
                REG_PHYDATA: phy_data <= wr_bus.data[15:0];
                REG_TIMEOUT: begin
                    wdog_period_led <= wr_bus.data[31];
                    wdog_period     <= wr_bus.data[15:0];
                end
                default: ;                  // version words are read only
            endcase
        end
    end

    // --------------------
    // register reads, zero wait
    always_comb begin
        case (read_off)
            REG_PHYCTRL:  board_rdata = {16'd0, phy_ctrl};
            REG_PHYDATA:  board_rdata = {16'd0, phy_data};
            REG_TIMEOUT:  board_rdata = {wdog_period_led, 12'd0, wdog_phase, wdog_period};
            REG_FVERSION: board_rdata = `FW_VERSION;
            REG_GIT_DESC: board_rdata = git_desc;
            default:      board_rdata = 32'd0;  // status and unused offsets
        endcase
    end

    // reboot moves only on the edge that takes a board write
    a_reboot_src: assert property (@(posedge sysclk) disable iff (rst)
        !$stable(reboot) |-> ($past(board_wen) || $past(rst)))
        else $error("reboot changed without a board write");

endmodule

/* board_top.sv */
/*
 * board register block top level
 *   bus control, board registers, watchdog
 *   array of channel register files
 */
`timescale 1ns/1ns
`include "board_defs.svh"

module board_top (
    input  logic                   sysclk,
    input  logic                   rst,
    input  logic [15:0]            reg_raddr,
    input  logic [15:0]            reg_waddr,
    input  logic [31:0]            reg_wdata,
    input  logic                   reg_wen,
    input  logic                   wdog_clear,
    output logic [31:0]            reg_rdata,
    output logic                   reboot,
    output logic                   wdog_period_led,
    output board_pkg::wdog_phase_e wdog_period_status,
    output logic                   wdog_timeout,
    output board_pkg::chan_cfg_t   chan_cfg [`NUM_CHAN]
);
    import board_pkg::*;

    bus_wr_t              wr_bus;       // decoded host write
    logic                 board_wen;
    logic [`NUM_CHAN-1:0] chan_wen;
    logic [3:0]           read_off;
    logic                 wdog_refresh;
    logic [31:0]          board_rdata;
    logic [31:0]          chan_rdata [`NUM_CHAN];
    logic [15:0]          wdog_period;

    reg_bus_ctrl u_ctrl (
        .sysclk(sysclk), .rst(rst),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .board_rdata(board_rdata), .chan_rdata(chan_rdata),
        .reg_rdata(reg_rdata), .wr_bus(wr_bus),
        .board_wen(board_wen), .chan_wen(chan_wen),
        .read_off(read_off), .wdog_refresh(wdog_refresh)
    );

    board_regs u_board (
        .sysclk(sysclk), .rst(rst),
        .wr_bus(wr_bus), .board_wen(board_wen), .read_off(read_off),
        .wdog_phase(wdog_period_status), .board_rdata(board_rdata),
        .reboot(reboot), .wdog_period(wdog_period),
        .wdog_period_led(wdog_period_led)
    );

    wdog_timer u_wdog (
        .sysclk(sysclk), .rst(rst),
        .wdog_period(wdog_period), .wdog_refresh(wdog_refresh),
        .wdog_clear(wdog_clear), .wdog_timeout(wdog_timeout),
        .wdog_phase(wdog_period_status)
    );

    // one register file per channel, block i+1
    for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
        chan_regs u_chan (
            .sysclk(sysclk), .rst(rst),
            .wr_bus(wr_bus), .chan_wen(chan_wen[i]), .read_off(read_off),
            .chan_rdata(chan_rdata[i]), .chan_cfg(chan_cfg[i])
        );
    end

endmodule

/* chan_regs.sv */
/*
 * single i/o channel register file
 *   dac setpoint and channel enable and mode
 */
`timescale 1ns/1ns

module chan_regs (
    input  logic                 sysclk,
    input  logic                 rst,
    input  board_pkg::bus_wr_t   wr_bus,
    input  logic                 chan_wen,      // this channel's write strobe
    input  logic [3:0]           read_off,
    output logic [31:0]          chan_rdata,
    output board_pkg::chan_cfg_t chan_cfg       // to the dac and channel logic
);
    import board_pkg::*;

    // --------------------
    // register writes
    always_ff @(posedge sysclk) begin
        if (rst) begin
            chan_cfg <= '0;                     // channel off, setpoint 0
        end else if (chan_wen) begin
            case (wr_bus.off)
                REG_DAC_SET: chan_cfg.dac_setpoint <= wr_bus.data[15:0];
                REG_CHAN_CTRL: begin
                    chan_cfg.enable <= wr_bus.data[0];
                    chan_cfg.mode   <= wr_bus.data[3:1];
                end
                default: ;                      // other offsets unused
            endcase
        end
    end

    // --------------------
    // readback
    always_comb begin
        case (read_off)
            REG_DAC_SET:   chan_rdata = {16'd0, chan_cfg.dac_setpoint};
            REG_CHAN_CTRL: chan_rdata = {28'd0, chan_cfg.mode, chan_cfg.enable};
            default:       chan_rdata = 32'd0;
        endcase
    end

endmodule

/* project.f */
+incdir+.
board_pkg.sv
reg_bus_ctrl.sv
board_regs.sv
wdog_timer.sv
chan_regs.sv
board_top.sv
tb_board.sv

/* reg_bus_ctrl.sv */
/*
 * host register bus control
 *   write address decode into board and channel strobes
 *   watchdog refresh on every host write
 *   read data select across blocks
 */
`timescale 1ns/1ns
`include "board_defs.svh"

module reg_bus_ctrl (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic [15:0]          reg_raddr,        // host read address
    input  logic [15:0]          reg_waddr,        // host write address
    input  logic [31:0]          reg_wdata,
    input  logic                 reg_wen,          // one cycle write strobe
    input  logic [31:0]          board_rdata,
    input  logic [31:0]          chan_rdata [`NUM_CHAN],
    output logic [31:0]          reg_rdata,
    output board_pkg::bus_wr_t   wr_bus,           // shared by all blocks
    output logic                 board_wen,
    output logic [`NUM_CHAN-1:0] chan_wen,
    output logic [3:0]           read_off,
    output logic                 wdog_refresh
);

    logic       wr_main;    // write hits the board space
    logic [3:0] wr_blk;     // write block number, reg address [7:4]
    logic       rd_main;
    logic [3:0] rd_blk;

    assign wr_main = (reg_waddr[15:12] == `ADDR_MAIN);
    assign wr_blk  = reg_waddr[7:4];
    assign rd_main = (reg_raddr[15:12] == `ADDR_MAIN);
    assign rd_blk  = reg_raddr[7:4];

    // --------------------
    // write path

    assign wr_bus    = '{off: reg_waddr[3:0], data: reg_wdata};
    assign board_wen = reg_wen && wr_main && (wr_blk == 4'd0);  // block 0 is the board file

    always_comb begin
        for (int i = 0; i < `NUM_CHAN; i++) begin
            chan_wen[i] = reg_wen && wr_main && (wr_blk == 4'(i + 1));  // blocks 1..N
        end
    end

    // any host write restarts the watchdog, mapped or not
    assign wdog_refresh = reg_wen;

    // --------------------
    // read path

    assign read_off = reg_raddr[3:0];   // each block decodes its own offset

    always_comb begin
        reg_rdata = 32'd0;              // unmapped space reads zero
        if (rd_main) begin
            if (rd_blk == 4'd0) begin
                reg_rdata = board_rdata;
            end
            for (int i = 0; i < `NUM_CHAN; i++) begin
                if (rd_blk == 4'(i + 1)) begin
                    reg_rdata = chan_rdata[i];
                end
            end
        end
    end

    // a host write lands in one block at most
    a_one_block: assert property (@(posedge sysclk) disable iff (rst)
        $onehot0({chan_wen, board_wen}))
        else $error("more than one block write strobe high");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the board register testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_board -o sim_board

# a fatal stop exits nonzero, so the log carries the verdict
./obj_dir/sim_board > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* tb_board.sv */
/*
 * self-checking testbench of the board register block
 *   shadow register model and expected read word
 *   reset values, random readback, reboot request
 *   watchdog phase classes and timeout timing
 */
`timescale 1ns/1ns
`include "board_defs.svh"

module tb_board;
    import board_pkg::*;

    logic        sysclk = 1'b0;
    logic        rst;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic        wdog_clear;
    logic [31:0] reg_rdata;
    logic        reboot;
    logic        wdog_period_led;
    logic        wdog_timeout;
    wdog_phase_e wdog_period_status;
    chan_cfg_t   chan_cfg [`NUM_CHAN];

    // shadow of everything the host wrote
    logic [15:0] sh_phy_ctrl;
    logic [15:0] sh_phy_data;
    logic [15:0] sh_period;
    logic        sh_led;
    logic        sh_reboot;
    logic [15:0] sh_dac [`NUM_CHAN];
    logic [3:0]  sh_ctrl [`NUM_CHAN];       // {mode, enable}

    logic        rd_pending = 1'b0;         // read waiting for the compare process
    logic [31:0] rd_exp;
    logic [15:0] rd_addr;
    int          err_count = 0;
    int          seed = 32'h4e6f;

    // every threshold and the value just above it
    logic [15:0] periods [11] = '{16'h0000, 16'h0001, `WDOG_TH1, `WDOG_TH1 + 16'd1,
        `WDOG_TH2, `WDOG_TH2 + 16'd1, `WDOG_TH3, `WDOG_TH3 + 16'd1,
        `WDOG_TH4, `WDOG_TH4 + 16'd1, 16'hFFFF};
    logic [31:0] status_wr [6] = '{32'h0030_0000, 32'h0020_0000, 32'h0030_0000,
        32'h0010_0000, 32'h0030_0000, 32'h0000_0000};

    board_top UUT (
        .sysclk(sysclk), .rst(rst),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen), .wdog_clear(wdog_clear),
        .reg_rdata(reg_rdata), .reboot(reboot), .wdog_period_led(wdog_period_led),
        .wdog_period_status(wdog_period_status), .wdog_timeout(wdog_timeout),
        .chan_cfg(chan_cfg)
    );

    always #10 sysclk = ~sysclk;            // 20 ns period

    // --------------------
    // reference model

    function automatic wdog_phase_e phase_of(input logic [15:0] p);
        if (p == 16'd0) return WDOG_DISABLE;
        if (p <= `WDOG_TH1) return PHASE_ONE;   // thresholds belong to the lower phase
        if (p <= `WDOG_TH2) return PHASE_TWO;
        if (p <= `WDOG_TH3) return PHASE_THREE;
        if (p <= `WDOG_TH4) return PHASE_FOUR;
        return PHASE_FIVE;
    endfunction

    function automatic logic [31:0] git_word();
        logic [1:0] rel;                    // firmware version against the tag
        if (`FW_VERSION == `GIT_FW_VERSION)
            rel = 2'd0;
        else if (`FW_VERSION == `GIT_FW_VERSION + 1)
            rel = 2'd1;
        else if (`FW_VERSION > `GIT_FW_VERSION + 1)
            rel = 2'd2;
        else
            rel = 2'd3;
        return {`GIT_SHA, `GIT_DIRTY, (`GIT_COMMITS != 0), rel};
    endfunction

    function automatic logic [31:0] expected_read(input logic [15:0] addr);
        int blk;
        blk = int'(addr[7:4]);
        if (addr[15:12] != `ADDR_MAIN) return 32'd0;
        if (blk == 0) begin
            case (addr[3:0])
                REG_PHYCTRL:  return {16'd0, sh_phy_ctrl};
                REG_PHYDATA:  return {16'd0, sh_phy_data};
                REG_TIMEOUT:  return {sh_led, 12'd0, phase_of(sh_period), sh_period};
                REG_FVERSION: return `FW_VERSION;
                REG_GIT_DESC: return git_word();
                default:      return 32'd0; // status reads zero
            endcase
        end
        if (blk <= `NUM_CHAN && addr[3:0] == REG_DAC_SET) return {16'd0, sh_dac[blk-1]};
        if (blk <= `NUM_CHAN && addr[3:0] == REG_CHAN_CTRL) return {28'd0, sh_ctrl[blk-1]};
        return 32'd0;
    endfunction

    function automatic void update_model(input logic [15:0] addr, input logic [31:0] data);
        int blk;
        blk = int'(addr[7:4]);
        if (addr[15:12] != `ADDR_MAIN) return;  // ignored, refresh only
        if (blk == 0) begin
            case (addr[3:0])
                REG_STATUS:  sh_reboot = data[21] & data[20];
                REG_PHYCTRL: sh_phy_ctrl = data[15:0];
                REG_PHYDATA: sh_phy_data = data[15:0];
                REG_TIMEOUT: begin
                    sh_led    = data[31];
                    sh_period = data[15:0];
                end
                default: ;
            endcase
        end else if (blk <= `NUM_CHAN) begin
            if (addr[3:0] == REG_DAC_SET)
                sh_dac[blk-1] = data[15:0];
            else if (addr[3:0] == REG_CHAN_CTRL)
                sh_ctrl[blk-1] = data[3:0];
        end
    endfunction

    // --------------------
    // checks and bus tasks

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // registered outputs against the shadow
    task automatic compare_outputs();
        check("reboot", 32'(reboot), 32'(sh_reboot));
        check("wdog_period_led", 32'(wdog_period_led), 32'(sh_led));
        for (int i = 0; i < `NUM_CHAN; i++) begin
            check($sformatf("chan_cfg[%0d].dac_setpoint", i),
                32'(chan_cfg[i].dac_setpoint), 32'(sh_dac[i]));
            check($sformatf("chan_cfg[%0d].enable", i),
                32'(chan_cfg[i].enable), 32'(sh_ctrl[i][0]));
            check($sformatf("chan_cfg[%0d].mode", i),
                32'(chan_cfg[i].mode), 32'(sh_ctrl[i][3:1]));
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(negedge sysclk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;                   // single cycle strobe
        @(negedge sysclk);
        reg_wen = 1'b0;
        update_model(addr, data);
    endtask

    task automatic read_reg(input logic [15:0] addr);
        int n;
        @(negedge sysclk);
        reg_raddr  = addr;
        rd_addr    = addr;
        rd_exp     = expected_read(addr);
        rd_pending = 1'b1;
        n = 0;
        while (rd_pending && n < 8) begin
            @(negedge sysclk);
            n++;
        end
        if (rd_pending) fail_run("read data was never compared");
    endtask

    task automatic pulse_clear();
        @(negedge sysclk);
        wdog_clear = 1'b1;
        @(negedge sysclk);
        wdog_clear = 1'b0;
    endtask

    // counts falling edges from the clearing edge until the flag is seen
    task automatic expect_timeout_after(input int cycles);
        int n;
        n = 0;
        while (!wdog_timeout && n < cycles + 2) begin
            @(negedge sysclk);
            n++;
        end
        if (!wdog_timeout) fail_run("watchdog timeout did not rise in time");
        if (n < cycles - 2) fail_run("watchdog timeout rose too early");
    endtask

    // compare process, mid low phase where read data is settled
    always @(negedge sysclk) begin
        #5;
        if (rd_pending) begin
            check($sformatf("reg_rdata @%h", rd_addr), reg_rdata, rd_exp);
            rd_pending = 1'b0;
        end
    end

    // hard stop for the whole run
    initial begin
        repeat (100000) @(posedge sysclk);
        fail_run("simulation cycle limit reached");
    end

    // --------------------
    // stimulus

    initial begin
        logic [31:0] sel;
        logic [31:0] data;
        logic [15:0] addr;
        int          chan;
        rst = 1'b1;
        reg_raddr = 16'd0;
        reg_waddr = 16'd0;
        reg_wdata = 32'd0;
        reg_wen = 1'b0;
        wdog_clear = 1'b0;
        sh_phy_ctrl = 16'd0;
        sh_phy_data = 16'd0;
        sh_period = `WDOG_PERIOD_RESET;
        sh_led = 1'b0;
        sh_reboot = 1'b0;
        for (int i = 0; i < `NUM_CHAN; i++) begin
            sh_dac[i]  = 16'd0;
            sh_ctrl[i] = 4'd0;
        end
        repeat (4) @(negedge sysclk);       // 4 cycles of reset
        rst = 1'b0;

        // reset values
        read_reg(16'h0003);
        read_reg(16'h0004);
        read_reg(16'h0005);
        compare_outputs();
        check("wdog_timeout", 32'(wdog_timeout), 32'd0);
        for (int i = 0; i < `NUM_CHAN; i++) begin
            read_reg(16'((i + 1) * 16 + 1));
        end

        // random writes with readback, mapped and unmapped
        for (int k = 0; k < 80; k++) begin
            sel  = $random(seed);
            data = $random(seed);
            chan = int'(sel[15:8]) % `NUM_CHAN;
            case (sel[2:0])
                3'd0: addr = 16'h0001;
                3'd1: addr = 16'h0002;
                3'd2: addr = 16'h0003;
                3'd3, 3'd4: addr = 16'((chan + 1) * 16 + int'(sel[16]));
                3'd5: addr = {1'b1, sel[14:0]};         // outside the board space
                default: addr = {4'h0, sel[11:0]};      // any block and offset
            endcase
            write_reg(addr, data);
            compare_outputs();
            read_reg(addr);
            read_reg(sel[31:16]);
        end

        // reboot request follows status writes only
        for (int k = 0; k < 6; k++) begin
            write_reg(16'h0000, status_wr[k]);
            check("reboot", 32'(reboot), 32'(sh_reboot));
            write_reg(16'h0002, $random(seed));
            repeat (3) @(negedge sysclk);
            check("reboot", 32'(reboot), 32'(sh_reboot));
            read_reg(16'h0000);
        end

        // period phase classes
        for (int k = 0; k < 11; k++) begin
            write_reg(16'h0003, {16'd0, periods[k]});
            check("wdog_period_status", 32'(wdog_period_status), 32'(phase_of(periods[k])));
            read_reg(16'h0003);
        end

        // ---- watchdog timeout
        write_reg(16'h0003, 32'd1);
        pulse_clear();
        check("wdog_timeout", 32'(wdog_timeout), 32'd0);
        write_reg(16'h2000, 32'd0);         // unmapped write restarts the count
        expect_timeout_after(32'(sh_period) * 256 + 1);
        repeat (50) @(negedge sysclk);
        check("wdog_timeout", 32'(wdog_timeout), 32'd1);
        write_reg(16'h00F0, 32'd0);
        check("wdog_timeout", 32'(wdog_timeout), 32'd1);   // write leaves the flag
        pulse_clear();
        check("wdog_timeout", 32'(wdog_timeout), 32'd0);
        repeat (200) @(negedge sysclk);
        write_reg(16'h0002, 32'h1234);      // late refresh pushes the timeout out
        expect_timeout_after(32'(sh_period) * 256 + 1);

        // period 0 never times out
        write_reg(16'h0003, 32'd0);
        pulse_clear();
        for (int k = 0; k < 2000; k++) begin
            @(negedge sysclk);
            check("wdog_timeout", 32'(wdog_timeout), 32'd0);
        end
        read_reg(16'h0003);

        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* wdog_timer.sv */
/*
 * watchdog timer
 *   counter cleared by host writes or clear, sticky timeout flag
 *   period phase classifier for the status led
 */
`timescale 1ns/1ns
`include "board_defs.svh"

module wdog_timer (
    input  logic                   sysclk,
    input  logic                   rst,
    input  logic [15:0]            wdog_period,     // 0 disables the watchdog
    input  logic                   wdog_refresh,    // any host write
    input  logic                   wdog_clear,      // e.g. on power up
    output logic                   wdog_timeout,    // sticky until clear or reset
    output board_pkg::wdog_phase_e wdog_phase
);
    import board_pkg::*;

    localparam int CNT_W = 16 + `WDOG_FRAC_BITS;

    logic [CNT_W-1:0] wdog_count;   // upper 16 bits against the period
    logic             period_hit;

    assign period_hit = (wdog_count[CNT_W-1 -: 16] == wdog_period);

    // --------------------
    // counter and flag
    always_ff @(posedge sysclk) begin
        if (rst || wdog_clear) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_refresh) begin
            wdog_count <= '0;           // flag survives a refresh
        end else if (wdog_period != 16'd0) begin
            if (period_hit) begin
                wdog_timeout <= 1'b1;   // counter parks at the period
            end else begin
                wdog_count <= wdog_count + 1'b1;
            end
        end
    end

    // --------------------
    // period phase, thresholds inclusive
    always_comb begin
        if (wdog_period == 16'd0)
            wdog_phase = WDOG_DISABLE;
        else if (wdog_period <= `WDOG_TH1)
            wdog_phase = PHASE_ONE;     // up to 50 ms
        else if (wdog_period <= `WDOG_TH2)
            wdog_phase = PHASE_TWO;
        else if (wdog_period <= `WDOG_TH3)
            wdog_phase = PHASE_THREE;
        else if (wdog_period <= `WDOG_TH4)
            wdog_phase = PHASE_FOUR;
        else
            wdog_phase = PHASE_FIVE;    // beyond 200 ms
    end

    // the flag only drops through clear or reset
    a_sticky: assert property (@(posedge sysclk) disable iff (rst)
        $fell(wdog_timeout) |-> ($past(wdog_clear) || $past(rst)))
        else $error("watchdog timeout fell without clear");

endmodule
